// ==== src/mem_pkg.sv ====
// shared memory geometry and config register map, referenced by scoped name from rtl and tb
package mem_pkg;

    // logical memory seen by the request port
    localparam int DATA_W = 64;                // word width
    localparam int ADDR_W = 8;                 // 256 words

    // one hard macro
    localparam int MACRO_W  = 32;              // macro data width
    localparam int MACRO_AW = 6;               // 64 words per macro

    // tiling grid derived from the two shapes above
    localparam int TILE_ROWS = 2 ** (ADDR_W - MACRO_AW);   // depth tiles
    localparam int TILE_COLS = DATA_W / MACRO_W;           // width slices

    // configuration bus
    localparam int CFG_AW = 2;
    localparam int CFG_DW = 8;

    // register map
    localparam logic [CFG_AW-1:0] REG_PROT_CTRL  = 2'd0;   // bit 0 enables protection
    localparam logic [CFG_AW-1:0] REG_PROT_BASE  = 2'd1;   // lowest protected word
    localparam logic [CFG_AW-1:0] REG_PROT_LIMIT = 2'd2;   // highest protected word, inclusive

endpackage

// ==== src/sram_macro_64x32.sv ====
// behavioural model of one 64x32 single-port macro, instantiated in a grid by the tiler
`timescale 1ns/1ps

module sram_macro_64x32 (
    input  logic                          clk,
    input  logic                          ce,      // chip enable
    input  logic                          we,      // write when set, read otherwise
    input  logic [mem_pkg::MACRO_AW-1:0]  addr,
    input  logic [mem_pkg::MACRO_W-1:0]   wmask,   // per bit write mask
    input  logic [mem_pkg::MACRO_W-1:0]   din,
    output logic [mem_pkg::MACRO_W-1:0]   dout
);

    logic [mem_pkg::MACRO_W-1:0] mem [0:(1 << mem_pkg::MACRO_AW)-1];

    // masked write, untouched bits keep old contents
    always_ff @(posedge clk) begin
        if (ce && we) begin
            mem[addr] <= (mem[addr] & ~wmask) | (din & wmask);
        end
    end

    // registered read port, holds while idle
    always_ff @(posedge clk) begin
        if (ce && !we) begin
            dout <= mem[addr];
        end
    end

    // an enabled access must carry a clean address
    addr_known_a : assert property (
        @(posedge clk) ce |-> !$isunknown(addr)
    ) else $error("sram_macro_64x32: unknown addr with ce high");

endmodule

// ==== src/spram_tiler.sv ====
// tiles 64x32 macros into the 256x64 memory by decoding rows and merging column read data
`timescale 1ns/1ps

module spram_tiler (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         ce,
    input  logic                         we,
    input  logic [mem_pkg::ADDR_W-1:0]   addr,
    input  logic [mem_pkg::DATA_W-1:0]   wmask,
    input  logic [mem_pkg::DATA_W-1:0]   din,
    output logic [mem_pkg::DATA_W-1:0]   dout
);

    logic [mem_pkg::ADDR_W-mem_pkg::MACRO_AW-1:0] row_sel;   // upper address bits
    logic [mem_pkg::ADDR_W-mem_pkg::MACRO_AW-1:0] row_q;     // row of last access
    logic [mem_pkg::MACRO_AW-1:0]                 macro_addr;
    logic [mem_pkg::TILE_ROWS-1:0]                row_ce;
    logic [mem_pkg::TILE_ROWS-1:0]                row_we;

    // outputs of every macro, indexed by row then column
    logic [mem_pkg::MACRO_W-1:0] macro_dout [mem_pkg::TILE_ROWS][mem_pkg::TILE_COLS];

    assign row_sel    = addr[mem_pkg::ADDR_W-1:mem_pkg::MACRO_AW];
    assign macro_addr = addr[mem_pkg::MACRO_AW-1:0];

    // remember which row the macros just answered for
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            row_q <= '0;
        end else if (ce) begin
            row_q <= row_sel;
        end
    end

    genvar r;
    genvar c;
    generate
        for (r = 0; r < mem_pkg::TILE_ROWS; r++) begin : g_row
            assign row_ce[r] = ce && (int'(row_sel) == r);   // only addressed row fires
            assign row_we[r] = we && (int'(row_sel) == r);

            for (c = 0; c < mem_pkg::TILE_COLS; c++) begin : g_col
                sram_macro_64x32 macro_i (
                    .clk   (clk),
                    .ce    (row_ce[r]),
                    .we    (row_we[r]),
                    .addr  (macro_addr),
                    .wmask (wmask[c*mem_pkg::MACRO_W +: mem_pkg::MACRO_W]),
                    .din   (din[c*mem_pkg::MACRO_W +: mem_pkg::MACRO_W]),
                    .dout  (macro_dout[r][c])
                );
            end
        end

        // column merge picks the slice from the registered row
        for (c = 0; c < mem_pkg::TILE_COLS; c++) begin : g_merge
            assign dout[c*mem_pkg::MACRO_W +: mem_pkg::MACRO_W] = macro_dout[row_q][c];
        end
    endgenerate

    // a row is only written while its chip enable is up
    row_we_ce_a : assert property (
        @(posedge clk) disable iff (!rst_n)
        (row_we & ~row_ce) == '0
    ) else $error("spram_tiler: row write enable without chip enable");

endmodule

// ==== src/mem_protect_regs.sv ====
// write-protect window registers with read-back, answers the port's protection check
`timescale 1ns/1ps

module mem_protect_regs (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         cfg_we,
    input  logic [mem_pkg::CFG_AW-1:0]   cfg_addr,
    input  logic [mem_pkg::CFG_DW-1:0]   cfg_wdata,
    output logic [mem_pkg::CFG_DW-1:0]   cfg_rdata,
    input  logic [mem_pkg::ADDR_W-1:0]   chk_addr,
    output logic                         chk_protected
);

    logic                        prot_en;      // window enable
    logic [mem_pkg::CFG_DW-1:0]  prot_base;    // first protected word
    logic [mem_pkg::CFG_DW-1:0]  prot_limit;   // last protected word

    // register writes
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prot_en    <= 1'b0;
            prot_base  <= '0;
            prot_limit <= '0;
        end else if (cfg_we) begin
            case (cfg_addr)
                mem_pkg::REG_PROT_CTRL:  prot_en    <= cfg_wdata[0];
                mem_pkg::REG_PROT_BASE:  prot_base  <= cfg_wdata;
                mem_pkg::REG_PROT_LIMIT: prot_limit <= cfg_wdata;
                default: ;                            // unmapped, ignored
            endcase
        end
    end

    // read-back mux
    always_comb begin
        case (cfg_addr)
            mem_pkg::REG_PROT_CTRL:  cfg_rdata = {{(mem_pkg::CFG_DW-1){1'b0}}, prot_en};
            mem_pkg::REG_PROT_BASE:  cfg_rdata = prot_base;
            mem_pkg::REG_PROT_LIMIT: cfg_rdata = prot_limit;
            default:                 cfg_rdata = '0;
        endcase
    end

    // inclusive window check; base above limit matches nothing
    assign chk_protected = prot_en
                        && (prot_base <= chk_addr)
                        && (chk_addr <= prot_limit);

endmodule

// ==== src/mem_req_port.sv ====
// valid/ready request front end that issues one tiler access per request and holds its response
`timescale 1ns/1ps

module mem_req_port (
    input  logic                         clk,
    input  logic                         rst_n,

    // request channel
    input  logic                         req_valid,
    output logic                         req_ready,
    input  logic                         req_write,
    input  logic [mem_pkg::ADDR_W-1:0]   req_addr,
    input  logic [mem_pkg::DATA_W-1:0]   req_wdata,
    input  logic [mem_pkg::DATA_W-1:0]   req_wmask,

    // response channel
    output logic                         rsp_valid,
    input  logic                         rsp_ready,
    output logic [mem_pkg::DATA_W-1:0]   rsp_rdata,
    output logic                         rsp_err,

    // protection check
    output logic [mem_pkg::ADDR_W-1:0]   chk_addr,
    input  logic                         chk_protected,

    // tiler access
    output logic                         mem_ce,
    output logic                         mem_we,
    output logic [mem_pkg::ADDR_W-1:0]   mem_addr,
    output logic [mem_pkg::DATA_W-1:0]   mem_wdata,
    output logic [mem_pkg::DATA_W-1:0]   mem_wmask,
    input  logic [mem_pkg::DATA_W-1:0]   mem_rdata
);

    logic accept;        // request handshake this cycle
    logic refused;       // write landing in the protected window
    logic rsp_done;      // pending response leaves this cycle

    assign rsp_done = rsp_valid && rsp_ready;

    // ready with a free slot or when the held response drains in the same cycle
    assign req_ready = !rsp_valid || rsp_ready;
    assign accept    = req_valid && req_ready;

    // protection is judged against the registers of the acceptance cycle
    assign chk_addr = req_addr;
    assign refused  = req_write && chk_protected;

    // access goes out in the acceptance cycle without an extra stage
    assign mem_ce    = accept;
    assign mem_we    = accept && req_write && !refused;   // drop protected writes
    assign mem_addr  = req_addr;
    assign mem_wdata = req_wdata;
    assign mem_wmask = req_wmask;

    // response goes valid one edge after the access is issued
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
        end else if (accept) begin
            rsp_valid <= 1'b1;
        end else if (rsp_done) begin
            rsp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rsp_err <= 1'b0;
        end else if (accept) begin
            rsp_err <= refused;                // set only for a refused write
        end
    end

    // the macros hold their output while no access happens, so read data
    // stays put for as long as the response waits
    assign rsp_rdata = mem_rdata;

    // a stalled response keeps its flag and the data coming up from the macros
    rsp_hold_a : assert property (
        @(posedge clk) disable iff (!rst_n)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_err) && $stable(rsp_rdata)
    ) else $error("mem_req_port: response changed under back-pressure");

endmodule

// ==== src/mem_subsys_top.sv ====
// top of the memory subsystem, wires request port, protection registers and macro tiler together
`timescale 1ns/1ps

module mem_subsys_top (
    input  logic                         clk,
    input  logic                         rst_n,

    // request channel
    input  logic                         req_valid,
    output logic                         req_ready,
    input  logic                         req_write,
    input  logic [mem_pkg::ADDR_W-1:0]   req_addr,
    input  logic [mem_pkg::DATA_W-1:0]   req_wdata,
    input  logic [mem_pkg::DATA_W-1:0]   req_wmask,

    // response channel
    output logic                         rsp_valid,
    input  logic                         rsp_ready,
    output logic [mem_pkg::DATA_W-1:0]   rsp_rdata,
    output logic                         rsp_err,

    // configuration bus
    input  logic                         cfg_we,
    input  logic [mem_pkg::CFG_AW-1:0]   cfg_addr,
    input  logic [mem_pkg::CFG_DW-1:0]   cfg_wdata,
    output logic [mem_pkg::CFG_DW-1:0]   cfg_rdata
);

    logic [mem_pkg::ADDR_W-1:0] chk_addr;
    logic                       chk_protected;

    logic                       mem_ce;
    logic                       mem_we;
    logic [mem_pkg::ADDR_W-1:0] mem_addr;
    logic [mem_pkg::DATA_W-1:0] mem_wdata;
    logic [mem_pkg::DATA_W-1:0] mem_wmask;
    logic [mem_pkg::DATA_W-1:0] mem_rdata;

    mem_req_port mem_req_port_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .req_write     (req_write),
        .req_addr      (req_addr),
        .req_wdata     (req_wdata),
        .req_wmask     (req_wmask),
        .rsp_valid     (rsp_valid),
        .rsp_ready     (rsp_ready),
        .rsp_rdata     (rsp_rdata),
        .rsp_err       (rsp_err),
        .chk_addr      (chk_addr),
        .chk_protected (chk_protected),
        .mem_ce        (mem_ce),
        .mem_we        (mem_we),
        .mem_addr      (mem_addr),
        .mem_wdata     (mem_wdata),
        .mem_wmask     (mem_wmask),
        .mem_rdata     (mem_rdata)
    );

    mem_protect_regs mem_protect_regs_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .cfg_we        (cfg_we),
        .cfg_addr      (cfg_addr),
        .cfg_wdata     (cfg_wdata),
        .cfg_rdata     (cfg_rdata),
        .chk_addr      (chk_addr),
        .chk_protected (chk_protected)
    );

    spram_tiler spram_tiler_i (
        .clk   (clk),
        .rst_n (rst_n),
        .ce    (mem_ce),
        .we    (mem_we),
        .addr  (mem_addr),
        .wmask (mem_wmask),
        .din   (mem_wdata),
        .dout  (mem_rdata)
    );

endmodule

// ==== tb/mem_subsys_tb.sv ====
// trace-driven testbench for the memory subsystem that is run from the project root
`timescale 1ns/1ps

module mem_subsys_tb;

    localparam int TIMEOUT_CYCLES = 200;

    logic                         clk;
    logic                         rst_n;
    logic                         req_valid;
    logic                         req_ready;
    logic                         req_write;
    logic [mem_pkg::ADDR_W-1:0]   req_addr;
    logic [mem_pkg::DATA_W-1:0]   req_wdata;
    logic [mem_pkg::DATA_W-1:0]   req_wmask;
    logic                         rsp_valid;
    logic                         rsp_ready;
    logic [mem_pkg::DATA_W-1:0]   rsp_rdata;
    logic                         rsp_err;
    logic                         cfg_we;
    logic [mem_pkg::CFG_AW-1:0]   cfg_addr;
    logic [mem_pkg::CFG_DW-1:0]   cfg_wdata;
    logic [mem_pkg::CFG_DW-1:0]   cfg_rdata;

    // responses still owed by the DUT with the oldest first
    logic [mem_pkg::DATA_W-1:0]   exp_rdata_q [$];
    logic                         exp_err_q [$];
    bit                           exp_is_read_q [$];

    logic [31:0] lfsr_state;
    int          checks;
    int          errors;
    int          test_errors;
    bit          aborted;

    mem_subsys_top mem_subsys_top_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req_write (req_write),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .req_wmask (req_wmask),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp_rdata (rsp_rdata),
        .rsp_err   (rsp_err),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;   // 4 ns period
    end

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // random response back-pressure from two bits per cycle
    initial begin
        logic bit_a;
        logic bit_b;
        rsp_ready  = 1'b0;
        lfsr_state = 32'h30d0_a53e;
        forever begin
            @(posedge clk);
            #1;
            lfsr_state = lfsr_next(lfsr_state);
            bit_a      = lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
            bit_b      = lfsr_state[0];
            rsp_ready  = bit_a | bit_b;   // high about three cycles in four
        end
    end

    task automatic count_error();
        errors++;
        test_errors++;
    endtask

    task automatic check_rdata(input logic [mem_pkg::DATA_W-1:0] expected,
                               input logic [mem_pkg::DATA_W-1:0] actual);
        checks++;
        if (actual !== expected) begin
            $display("mismatch at %0t: rsp_rdata expected %h, got %h", $time, expected, actual);
            count_error();
        end
    endtask

    task automatic check_err(input logic expected, input logic actual);
        checks++;
        if (actual !== expected) begin
            $display("mismatch at %0t: rsp_err expected %b, got %b", $time, expected, actual);
            count_error();
        end
    endtask

    task automatic check_cfg(input logic [mem_pkg::CFG_DW-1:0] expected,
                             input logic [mem_pkg::CFG_DW-1:0] actual);
        checks++;
        if (actual !== expected) begin
            $display("mismatch at %0t: cfg_rdata expected %h, got %h", $time, expected, actual);
            count_error();
        end
    endtask

    task automatic report_abort(input string why);
        aborted = 1'b1;
        $display("%s at %0t", why, $time);
    endtask

    // response monitor judges a transfer by the levels seen mid-cycle
    initial begin
        forever begin
            @(negedge clk);
            if (rst_n && rsp_valid && rsp_ready) begin
                if (exp_err_q.size() == 0) begin
                    $display("response at %0t arrived with no request outstanding", $time);
                    count_error();
                end else begin
                    if (exp_is_read_q[0]) begin
                        check_rdata(exp_rdata_q[0], rsp_rdata);
                    end
                    check_err(exp_err_q[0], rsp_err);
                    void'(exp_rdata_q.pop_front());
                    void'(exp_err_q.pop_front());
                    void'(exp_is_read_q.pop_front());
                end
            end
        end
    end

    // entered and left 1 ns after a rising edge
    task automatic send_request(input logic write,
                                input logic [mem_pkg::ADDR_W-1:0] addr,
                                input logic [mem_pkg::DATA_W-1:0] data,
                                input logic [mem_pkg::DATA_W-1:0] mask,
                                input logic [mem_pkg::DATA_W-1:0] exp_data,
                                input logic exp_err);
        int waited;
        waited    = 0;
        req_valid = 1'b1;
        req_write = write;
        req_addr  = addr;
        req_wdata = data;
        req_wmask = mask;
        @(negedge clk);
        while (!req_ready && !aborted) begin
            waited++;
            if (waited >= TIMEOUT_CYCLES) begin
                report_abort("timeout waiting for req_ready");
            end else begin
                @(negedge clk);
            end
        end
        if (!aborted) begin
            exp_rdata_q.push_back(exp_data);   // accepted at the coming edge
            exp_err_q.push_back(exp_err);
            exp_is_read_q.push_back(!write);
            @(posedge clk);
            #1;
        end
    endtask

    task automatic drain_responses();
        int waited;
        waited    = 0;
        req_valid = 1'b0;
        while (exp_err_q.size() != 0 && !aborted) begin
            waited++;
            if (waited >= TIMEOUT_CYCLES) begin
                report_abort("timeout waiting for outstanding responses");
            end else begin
                @(posedge clk);
                #1;
            end
        end
    endtask

    task automatic write_cfg(input logic [mem_pkg::CFG_AW-1:0] addr,
                             input logic [mem_pkg::CFG_DW-1:0] data);
        cfg_we    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        @(posedge clk);
        #1;
        cfg_we = 1'b0;
    endtask

    task automatic read_cfg(input logic [mem_pkg::CFG_AW-1:0] addr,
                            input logic [mem_pkg::CFG_DW-1:0] expected);
        cfg_addr = addr;
        @(negedge clk);
        check_cfg(expected, cfg_rdata);   // combinational read-back
        @(posedge clk);
        #1;
    endtask

    task automatic finish_test(input int num);
        drain_responses();
        $display("test %0d done: %0d errors", num, test_errors);
        test_errors = 0;
    endtask

    initial begin
        int               fd;
        int               code;
        int               f_test;
        int               cur_test;
        string            line;
        logic [7:0]       op;
        logic [63:0]      f_addr;
        logic [63:0]      f_data;
        logic [63:0]      f_mask;
        logic [63:0]      f_exp;
        logic [63:0]      f_err;
        req_valid   = 1'b0;
        req_write   = 1'b0;
        req_addr    = '0;
        req_wdata   = '0;
        req_wmask   = '0;
        cfg_we      = 1'b0;
        cfg_addr    = '0;
        cfg_wdata   = '0;
        rst_n       = 1'b0;
        checks      = 0;
        errors      = 0;
        test_errors = 0;
        aborted     = 1'b0;
        cur_test    = 0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        fd = $fopen("tb/mem_trace.txt", "r");
        if (fd == 0) begin
            report_abort("could not open the trace file tb/mem_trace.txt");
        end else begin
            while (!aborted && $fgets(line, fd) != 0) begin
                if (line.len() < 2 || line[0] == "#") begin
                    continue;   // blank or comment line
                end
                code = $sscanf(line, "%c %h %h %h %h %h %d",
                               op, f_addr, f_data, f_mask, f_exp, f_err, f_test);
                if (code != 7) begin
                    report_abort("malformed line in the trace file");
                end else begin
                    if (f_test != cur_test) begin
                        if (cur_test != 0) begin
                            finish_test(cur_test);
                        end
                        cur_test = f_test;
                    end
                    if (!aborted) begin
                        case (op)
                            "W": send_request(1'b1, f_addr[mem_pkg::ADDR_W-1:0], f_data,
                                              f_mask, f_exp, f_err[0]);
                            "R": send_request(1'b0, f_addr[mem_pkg::ADDR_W-1:0], f_data,
                                              f_mask, f_exp, f_err[0]);
                            "C": begin
                                drain_responses();   // keep config after earlier traffic
                                write_cfg(f_addr[mem_pkg::CFG_AW-1:0],
                                          f_data[mem_pkg::CFG_DW-1:0]);
                            end
                            "Q": begin
                                drain_responses();
                                read_cfg(f_addr[mem_pkg::CFG_AW-1:0],
                                         f_exp[mem_pkg::CFG_DW-1:0]);
                            end
                            default: report_abort("unknown op letter in the trace file");
                        endcase
                    end
                end
            end
            $fclose(fd);
            if (!aborted && cur_test != 0) begin
                finish_test(cur_test);
            end
        end

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0 && !aborted) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== tb/mem_trace.txt ====
# op addr data mask exp_rdata exp_err test, all hex except the decimal test number
# op is C config write, Q config read-back, W write, R read; for Q exp_rdata is the register value
W 00 11110000aaaa0000 ffffffffffffffff 0000000000000000 0 1
W 3f 3f3f3f3fc0c0c0c0 ffffffffffffffff 0000000000000000 0 1
W 40 40404040bfbfbfbf ffffffffffffffff 0000000000000000 0 1
W bf bfbfbfbfdeadbeef ffffffffffffffff 0000000000000000 0 1
W c0 c0c0c0c0cafef00d ffffffffffffffff 0000000000000000 0 1
W ff ffeeddccbbaa9988 ffffffffffffffff 0000000000000000 0 1
R 40 0000000000000000 0000000000000000 40404040bfbfbfbf 0 1
R 3f 0000000000000000 0000000000000000 3f3f3f3fc0c0c0c0 0 1
R c0 0000000000000000 0000000000000000 c0c0c0c0cafef00d 0 1
R bf 0000000000000000 0000000000000000 bfbfbfbfdeadbeef 0 1
R 00 0000000000000000 0000000000000000 11110000aaaa0000 0 1
R ff 0000000000000000 0000000000000000 ffeeddccbbaa9988 0 1
W 10 0123456789abcdef ffffffffffffffff 0000000000000000 0 2
W 10 ffffffffffffffff 000000000000ffff 0000000000000000 0 2
R 10 0000000000000000 0000000000000000 0123456789abffff 0 2
W 10 0000000000000000 ff00000000000000 0000000000000000 0 2
R 10 0000000000000000 0000000000000000 0023456789abffff 0 2
W 20 fedcba9876543210 ffffffffffffffff 0000000000000000 0 2
W 20 a5a5a5a55a5a5a5a 00000000ffffffff 0000000000000000 0 2
R 20 0000000000000000 0000000000000000 fedcba985a5a5a5a 0 2
W 20 13579bdf00000000 ffffffff00000000 0000000000000000 0 2
R 20 0000000000000000 0000000000000000 13579bdf5a5a5a5a 0 2
W 20 ffffffffffffffff 0f0f0f0f0f0f0f0f 0000000000000000 0 2
R 20 0000000000000000 0000000000000000 1f5f9fdf5f5f5f5f 0 2
C 01 0000000000000030 0000000000000000 0000000000000000 0 3
C 02 000000000000003f 0000000000000000 0000000000000000 0 3
Q 01 0000000000000000 0000000000000000 0000000000000030 0 3
Q 02 0000000000000000 0000000000000000 000000000000003f 0 3
Q 00 0000000000000000 0000000000000000 0000000000000000 0 3
Q 03 0000000000000000 0000000000000000 0000000000000000 0 3
C 03 00000000000000ff 0000000000000000 0000000000000000 0 3
Q 03 0000000000000000 0000000000000000 0000000000000000 0 3
W 30 aaaa5555aaaa5555 ffffffffffffffff 0000000000000000 0 4
C 00 0000000000000001 0000000000000000 0000000000000000 0 4
W 30 1234567812345678 ffffffffffffffff 0000000000000000 1 4
R 30 0000000000000000 0000000000000000 aaaa5555aaaa5555 0 4
W 3f 0000000000000000 ffffffffffffffff 0000000000000000 1 4
R 3f 0000000000000000 0000000000000000 3f3f3f3fc0c0c0c0 0 4
W 2f 2f2f2f2f2f2f2f2f ffffffffffffffff 0000000000000000 0 4
W 40 4141414141414141 ffffffffffffffff 0000000000000000 0 4
R 2f 0000000000000000 0000000000000000 2f2f2f2f2f2f2f2f 0 4
R 40 0000000000000000 0000000000000000 4141414141414141 0 4
C 00 0000000000000000 0000000000000000 0000000000000000 0 4
W 30 0f0f0f0f0f0f0f0f ffffffffffffffff 0000000000000000 0 4
R 30 0000000000000000 0000000000000000 0f0f0f0f0f0f0f0f 0 4
W 50 5050505050505050 ffffffffffffffff 0000000000000000 0 5
W 51 5151515151515151 ffffffffffffffff 0000000000000000 0 5
R 50 0000000000000000 0000000000000000 5050505050505050 0 5
R 51 0000000000000000 0000000000000000 5151515151515151 0 5
W 52 5252525252525252 ffffffffffffffff 0000000000000000 0 5
R 52 0000000000000000 0000000000000000 5252525252525252 0 5
R 00 0000000000000000 0000000000000000 11110000aaaa0000 0 5
R ff 0000000000000000 0000000000000000 ffeeddccbbaa9988 0 5
W 50 ffffffffffffffff 00ff00ff00ff00ff 0000000000000000 0 5
R 50 0000000000000000 0000000000000000 50ff50ff50ff50ff 0 5
W 51 0000000000000000 0000000000000000 0000000000000000 0 5
R 51 0000000000000000 0000000000000000 5151515151515151 0 5
R 40 0000000000000000 0000000000000000 4141414141414141 0 5

// ==== vlog.f ====
src/mem_pkg.sv
src/sram_macro_64x32.sv
src/spram_tiler.sv
src/mem_protect_regs.sv
src/mem_req_port.sv
src/mem_subsys_top.sv
tb/mem_subsys_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds and runs the memory subsystem testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -f vlog.f \
    --top-module mem_subsys_tb -Mdir obj_dir -o mem_subsys_sim > build.log 2>&1 \
    && ./obj_dir/mem_subsys_sim > sim.log 2>&1
grep -qx "No errors" sim.log && echo "simulation passed" && exit 0
echo "simulation failed, see build.log and sim.log"
exit 1
